//--- Bender.yml
package:
  name: bcd_display

sources:
  - src/bcd_display_pkg.sv
  - src/bin2bcd_16.sv
  - src/sample_queue.sv
  - src/display_config.sv
  - src/digit_formatter.sv
  - src/digit_scanner.sv
  - src/bcd_display_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/bcd_display_tb.sv

//--- bcd_display_top.f
+incdir+include
src/bcd_display_pkg.sv
src/bin2bcd_16.sv
src/sample_queue.sv
src/display_config.sv
src/digit_formatter.sv
src/digit_scanner.sv
src/bcd_display_top.sv
bench/bcd_display_tb.sv

//--- include/display_vectors.svh
/*
  stimulus table for the display testbench, one row per sample
  digits run ten-thousands down to ones, 4'hf marks a blanked digit
  a row with enable 0 leaves its sample queued for the row after it
*/
`ifndef DISPLAY_VECTORS_SVH
`define DISPLAY_VECTORS_SVH

typedef struct packed {
  bcd_display_pkg::bin16_t    value;
  logic                       enable;
  logic                       blank_lz;
  logic [7:0]                 scan_div;
  bcd_display_pkg::bcd_word_t digits;
} vector_row_t;

localparam int NUM_ROWS = 12;

// value, enable, blank_lz, scan_div, expected digits
localparam vector_row_t VECTORS [NUM_ROWS] = '{
  '{16'd0,     1'b1, 1'b0, 8'd0,  20'h00000},
  '{16'd7,     1'b1, 1'b1, 8'd0,  20'hffff7},
  '{16'd10,    1'b1, 1'b0, 8'd3,  20'h00010},
  '{16'd99,    1'b1, 1'b1, 8'd3,  20'hfff99},
  '{16'd100,   1'b1, 1'b1, 8'd17, 20'hff100},
  '{16'd40000, 1'b1, 1'b0, 8'd17, 20'h40000},
  '{16'd65535, 1'b1, 1'b1, 8'd0,  20'h65535},
  '{16'd0,     1'b1, 1'b1, 8'd3,  20'hffff0},
  '{16'd12345, 1'b0, 1'b0, 8'd3,  20'h12345},
  '{16'd305,   1'b1, 1'b1, 8'd0,  20'hff305},
  '{16'd9999,  1'b1, 1'b0, 8'd17, 20'h09999},
  '{16'd50001, 1'b1, 1'b1, 8'd3,  20'h50001}
};

`endif

//--- bench/bcd_display_tb.sv
/*
  testbench for the five-digit display driver
  the table rows run first and random sample pairs follow them
*/
`timescale 1ns/1ps

module bcd_display_tb;

  `include "display_vectors.svh"

  localparam int RESET_CYCLES = 16;
  localparam int NUM_RANDOM   = 6;
  localparam int LIMIT_CYCLES =
    (NUM_ROWS + NUM_RANDOM) * bcd_display_pkg::NUM_DIGITS * 256 * 3 + RESET_CYCLES;

  // standard patterns with segment g in the top bit
  localparam bcd_display_pkg::seg_t SEG_PATTERNS [10] = '{
    7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07, 7'h7f, 7'h6f
  };

  logic                        clk;
  logic                        rst_n;
  bcd_display_pkg::sample_t    sample;
  logic                        credit_return;
  logic                        cfg_we;
  logic                        cfg_addr;
  logic [7:0]                  cfg_wdata;
  bcd_display_pkg::digit_sel_t digit_sel;
  bcd_display_pkg::seg_t       segments;
  bcd_display_pkg::bcd_t       seen_digit;

  bcd_display_pkg::bin16_t pending [$];
  bcd_display_pkg::bin16_t shown;
  int sent;
  int returned;
  int seed = 32'h1a0f_77dc;

  bcd_display_top uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .sample        (sample),
    .credit_return (credit_return),
    .cfg_we        (cfg_we),
    .cfg_addr      (cfg_addr),
    .cfg_wdata     (cfg_wdata),
    .digit_sel     (digit_sel),
    .segments      (segments)
  );

  always #4 clk = ~clk;

  // 4'hf stands for a blank digit and 4'he for a pattern that is no digit
  function automatic bcd_display_pkg::bcd_t decode_segments(input bcd_display_pkg::seg_t seg);
    if (seg == bcd_display_pkg::SEG_BLANK) begin
      return 4'hf;
    end
    for (int i = 0; i < 10; i++) begin
      if (seg == SEG_PATTERNS[i]) begin
        return bcd_display_pkg::bcd_t'(i);
      end
    end
    return 4'he;
  endfunction

  assign seen_digit = decode_segments(segments);

  function automatic bcd_display_pkg::bcd_word_t expect_digits(
    input bcd_display_pkg::bin16_t v,
    input logic                    blank_lz
  );
    logic [19:0] w;
    int          rest;
    logic        lead;
    rest = v;
    for (int i = 0; i < bcd_display_pkg::NUM_DIGITS; i++) begin
      w[4*i +: 4] = bcd_display_pkg::bcd_t'(rest % 10);
      rest = rest / 10;
    end
    lead = blank_lz;
    for (int i = bcd_display_pkg::NUM_DIGITS - 1; i >= 1; i--) begin
      lead = lead && (w[4*i +: 4] == 4'd0);
      if (lead) begin
        w[4*i +: 4] = 4'hf;
      end
    end
    return w;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_digit(input string name, input bcd_display_pkg::bcd_t got,
                             input bcd_display_pkg::bcd_t exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_segments(input string name, input bcd_display_pkg::seg_t got,
                                input bcd_display_pkg::seg_t exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_digit_sel(input string name, input bcd_display_pkg::digit_sel_t got,
                                 input bcd_display_pkg::digit_sel_t exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      report_failure($sformatf("FAIL at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic write_cfg(input logic addr, input logic [7:0] data);
    @(posedge clk);
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge clk);
    cfg_we <= 1'b0;
  endtask

  // holds valid low while no credit is left
  task automatic send_sample(input bcd_display_pkg::bin16_t v);
    @(posedge clk);
    while (sent - returned >= bcd_display_pkg::QUEUE_DEPTH) begin
      sample.valid <= 1'b0;
      @(posedge clk);
    end
    sample <= '{valid: 1'b1, value: v};
    sent   <= sent + 1;
    pending.push_back(v);
  endtask

  task automatic stop_sending();
    @(posedge clk);
    sample.valid <= 1'b0;
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_digit_sel("digit_sel", digit_sel, '0);
      check_segments("segments", segments, bcd_display_pkg::SEG_BLANK);
      check_count("credit_return", int'(credit_return), 0);
    end
  endtask

  task automatic prepare_display(input logic blank_lz, input logic [7:0] div);
    write_cfg(bcd_display_pkg::CFG_ADDR_CTRL, {6'd0, blank_lz, 1'b0});
    repeat (2) @(posedge clk);
    check_idle(4);
    write_cfg(bcd_display_pkg::CFG_ADDR_SCAN, div);
  endtask

  // enable is registered at the write edge and the ones digit follows one cycle later
  task automatic check_scan_start();
    @(negedge clk);
    check_digit_sel("digit_sel", digit_sel, '0);
    @(negedge clk);
    check_digit_sel("digit_sel", digit_sel, bcd_display_pkg::digit_sel_t'(1));
  endtask

  // starts in the first cycle of the ones slot and ends in the first cycle of the next frame
  task automatic check_frame(input bcd_display_pkg::bcd_word_t exp, input logic [7:0] div);
    logic [19:0]                 exp_bits;
    bcd_display_pkg::digit_sel_t sel;
    int                          cycles;
    exp_bits = exp;
    for (int d = 0; d < bcd_display_pkg::NUM_DIGITS; d++) begin
      sel    = bcd_display_pkg::digit_sel_t'(1 << d);
      cycles = 0;
      check_digit_sel("digit_sel", digit_sel, sel);
      while (digit_sel == sel && cycles <= 256) begin
        check_digit($sformatf("segments of digit %0d", d), seen_digit, exp_bits[4*d +: 4]);
        cycles++;
        @(negedge clk);
      end
      check_count($sformatf("slot length of digit %0d", d), cycles, int'(div) + 1);
    end
  endtask

  // the first frame still shows the previous value and each queued value gets one frame
  task automatic run_display(input logic blank_lz, input logic [7:0] div,
                             input bcd_display_pkg::bcd_word_t last_exp);
    write_cfg(bcd_display_pkg::CFG_ADDR_CTRL, {6'd0, blank_lz, 1'b1});
    check_scan_start();
    check_frame(expect_digits(shown, blank_lz), div);
    while (pending.size() > 1) begin
      shown = pending.pop_front();
      check_frame(expect_digits(shown, blank_lz), div);
    end
    shown = pending.pop_front();
    check_frame(last_exp, div);
    check_count("credit_return pulses", returned, sent);
  endtask

  task automatic run_row(input vector_row_t row);
    prepare_display(row.blank_lz, row.scan_div);
    send_sample(row.value);
    stop_sending();
    if (row.enable) begin
      run_display(row.blank_lz, row.scan_div, row.digits);
    end else begin
      check_idle(40);
    end
  endtask

  always @(posedge clk) begin
    if (rst_n && credit_return === 1'b1) begin
      if (returned >= sent) begin
        report_failure("a credit came back with no sample outstanding");
      end
      returned <= returned + 1;
    end
  end

  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk);
    report_failure($sformatf("timeout, the run did not finish within %0d cycles", LIMIT_CYCLES));
  end

  initial begin
    bcd_display_pkg::bin16_t first;
    bcd_display_pkg::bin16_t second;
    logic [7:0]              div;
    logic                    blank;
    clk       = 1'b0;
    rst_n     <= 1'b0;
    sample    <= '0;
    cfg_we    <= 1'b0;
    cfg_addr  <= 1'b0;
    cfg_wdata <= 8'd0;
    shown     = '0;
    sent      = 0;
    returned  = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    check_idle(8);

    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(VECTORS[r]);
    end

    // random pairs sent as a burst that uses up every credit
    for (int i = 0; i < NUM_RANDOM; i++) begin
      first  = bcd_display_pkg::bin16_t'($random(seed));
      second = bcd_display_pkg::bin16_t'($random(seed));
      div    = (i % 3 == 0) ? 8'd0 : ((i % 3 == 1) ? 8'd3 : 8'd17);
      blank  = (i % 2 == 1);
      prepare_display(blank, div);
      send_sample(first);
      send_sample(second);
      stop_sending();
      check_count("outstanding credits", sent - returned, bcd_display_pkg::QUEUE_DEPTH);
      run_display(blank, div, expect_digits(second, blank));
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

//--- src/bcd_display_pkg.sv
/*
  shared widths, types and constants for the five-digit decimal display
  samples are 16-bit unsigned, so five BCD digits always suffice
*/
package bcd_display_pkg;

  localparam int NUM_DIGITS  = 5;
  // receive queue size, also the number of credits the sender starts with
  localparam int QUEUE_DEPTH = 2;

  typedef logic [15:0]           bin16_t;
  typedef logic [3:0]            bcd_t;
  // segment order is g down to a, active high
  typedef logic [6:0]            seg_t;
  // bit 0 is the ones digit
  typedef logic [NUM_DIGITS-1:0] digit_sel_t;

  localparam seg_t SEG_BLANK     = 7'b000_0000;
  localparam logic CFG_ADDR_CTRL = 1'b0;
  localparam logic CFG_ADDR_SCAN = 1'b1;

  // most significant digit sits in the top bits
  typedef struct packed {
    bcd_t ten_thousands;
    bcd_t thousands;
    bcd_t hundreds;
    bcd_t tens;
    bcd_t ones;
  } bcd_word_t;

  typedef struct packed {
    logic   valid;
    bin16_t value;
  } sample_t;

  typedef struct packed {
    logic       enable;
    logic       blank_lz;
    logic [7:0] scan_div;
  } display_cfg_t;

  typedef enum logic {SCAN_IDLE, SCAN_RUN} scan_state_t;

  // one correction step of the shift-and-add-3 conversion
  function automatic bcd_t add3(input bcd_t d);
    return (d >= 4'd5) ? bcd_t'(d + 4'd3) : d;
  endfunction

endpackage

//--- src/bcd_display_top.sv
/*
  five-digit decimal display driver for 16-bit unsigned samples
  samples arrive under credit flow control, one is shown per scan frame
*/
`timescale 1ns/1ps

module bcd_display_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  bcd_display_pkg::sample_t    sample,
  output logic                        credit_return,
  input  logic                        cfg_we,
  input  logic                        cfg_addr,
  input  logic [7:0]                  cfg_wdata,
  output bcd_display_pkg::digit_sel_t digit_sel,
  output bcd_display_pkg::seg_t       segments
);

  bcd_display_pkg::display_cfg_t cfg;
  bcd_display_pkg::sample_t      pop_sample;
  bcd_display_pkg::bcd_word_t    bcd;
  logic                          frame_done;

  display_config u_config (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg)
  );

  // the end of each frame pulls the next sample
  sample_queue u_queue (
    .clk           (clk),
    .rst_n         (rst_n),
    .sample        (sample),
    .pop_req       (frame_done),
    .pop_sample    (pop_sample),
    .credit_return (credit_return)
  );

  bin2bcd_16 u_bin2bcd (
    .bin (pop_sample.value),
    .bcd (bcd)
  );

  digit_formatter u_formatter (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (pop_sample.valid),
    .bcd_in    (bcd),
    .blank_lz  (cfg.blank_lz),
    .digit_sel (digit_sel),
    .segments  (segments)
  );

  digit_scanner u_scanner (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable     (cfg.enable),
    .scan_div   (cfg.scan_div),
    .digit_sel  (digit_sel),
    .frame_done (frame_done)
  );

endmodule

//--- src/bin2bcd_16.sv
/*
  purely combinational 16-bit binary to BCD conversion
  the top digit never exceeds 6, so no sixth digit is produced
*/
`timescale 1ns/1ps

module bin2bcd_16 (
  input  bcd_display_pkg::bin16_t    bin,
  output bcd_display_pkg::bcd_word_t bcd
);

  // d is the input of each correction stage, c its output
  bcd_display_pkg::bcd_t d [1:35];
  bcd_display_pkg::bcd_t c [1:35];

  // first column shifts in the sample bits
  assign d[1]  = {1'b0, bin[15:13]};
  assign d[2]  = {c[1][2:0], bin[12]};
  assign d[3]  = {c[2][2:0], bin[11]};
  assign d[4]  = {c[3][2:0], bin[10]};
  assign d[5]  = {c[4][2:0], bin[9]};
  assign d[6]  = {c[5][2:0], bin[8]};
  assign d[7]  = {c[6][2:0], bin[7]};
  assign d[8]  = {c[7][2:0], bin[6]};
  assign d[9]  = {c[8][2:0], bin[5]};
  assign d[10] = {c[9][2:0], bin[4]};
  assign d[11] = {c[10][2:0], bin[3]};
  assign d[12] = {c[11][2:0], bin[2]};
  assign d[13] = {c[12][2:0], bin[1]};

  // second column takes the carries out of the first
  assign d[14] = {1'b0, c[1][3], c[2][3], c[3][3]};
  assign d[15] = {c[14][2:0], c[4][3]};
  assign d[16] = {c[15][2:0], c[5][3]};
  assign d[17] = {c[16][2:0], c[6][3]};
  assign d[18] = {c[17][2:0], c[7][3]};
  assign d[19] = {c[18][2:0], c[8][3]};
  assign d[20] = {c[19][2:0], c[9][3]};
  assign d[21] = {c[20][2:0], c[10][3]};
  assign d[22] = {c[21][2:0], c[11][3]};
  assign d[23] = {c[22][2:0], c[12][3]};

  assign d[24] = {1'b0, c[14][3], c[15][3], c[16][3]};
  assign d[25] = {c[24][2:0], c[17][3]};
  assign d[26] = {c[25][2:0], c[18][3]};
  assign d[27] = {c[26][2:0], c[19][3]};
  assign d[28] = {c[27][2:0], c[20][3]};
  assign d[29] = {c[28][2:0], c[21][3]};
  assign d[30] = {c[29][2:0], c[22][3]};

  assign d[31] = {1'b0, c[24][3], c[25][3], c[26][3]};
  assign d[32] = {c[31][2:0], c[27][3]};
  assign d[33] = {c[32][2:0], c[28][3]};
  assign d[34] = {c[33][2:0], c[29][3]};

  assign d[35] = {1'b0, c[31][3], c[32][3], c[33][3]};

  for (genvar i = 1; i <= 35; i++) begin : g_stage
    assign c[i] = bcd_display_pkg::add3(d[i]);
  end

  // digits are read off the bottom of each column
  assign bcd.ones          = {c[13][2:0], bin[0]};
  assign bcd.tens          = {c[23][2:0], c[13][3]};
  assign bcd.hundreds      = {c[30][2:0], c[23][3]};
  assign bcd.thousands     = {c[34][2:0], c[30][3]};
  assign bcd.ten_thousands = {c[35][2:0], c[34][3]};

endmodule

//--- src/digit_formatter.sv
/*
  holds the displayed BCD word and its seven-segment patterns
  a zero digit_sel shows a blank display, the ones digit is never blanked
*/
`timescale 1ns/1ps

module digit_formatter (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       load,
  input  bcd_display_pkg::bcd_word_t bcd_in,
  input  logic                       blank_lz,
  input  bcd_display_pkg::digit_sel_t digit_sel,
  output bcd_display_pkg::seg_t      segments
);

  bcd_display_pkg::bcd_word_t                              digit_q;
  bcd_display_pkg::bcd_t [bcd_display_pkg::NUM_DIGITS-1:0] digits;
  bcd_display_pkg::seg_t  seg_next [bcd_display_pkg::NUM_DIGITS];
  bcd_display_pkg::seg_t  seg_q    [bcd_display_pkg::NUM_DIGITS];
  logic                   lead_zero;

  function automatic bcd_display_pkg::seg_t seg7(input bcd_display_pkg::bcd_t d);
    case (d)
      4'd0:    return 7'h3f;
      4'd1:    return 7'h06;
      4'd2:    return 7'h5b;
      4'd3:    return 7'h4f;
      4'd4:    return 7'h66;
      4'd5:    return 7'h6d;
      4'd6:    return 7'h7d;
      4'd7:    return 7'h07;
      4'd8:    return 7'h7f;
      4'd9:    return 7'h6f;
      default: return bcd_display_pkg::SEG_BLANK;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      digit_q <= '0;
    end else if (load) begin
      digit_q <= bcd_in;
    end
  end

  // a freshly popped word is encoded right away so the next frame shows it
  always_comb begin
    digits    = load ? bcd_in : digit_q;
    lead_zero = blank_lz;
    for (int i = bcd_display_pkg::NUM_DIGITS - 1; i >= 0; i--) begin
      lead_zero   = lead_zero && (digits[i] == 4'd0) && (i != 0);
      seg_next[i] = lead_zero ? bcd_display_pkg::SEG_BLANK : seg7(digits[i]);
    end
  end

  always_ff @(posedge clk) begin
    seg_q <= seg_next;
  end

  // digit_sel is registered in the scanner, so segments change on its edge
  always_comb begin
    segments = bcd_display_pkg::SEG_BLANK;
    for (int i = 0; i < bcd_display_pkg::NUM_DIGITS; i++) begin
      if (digit_sel[i]) segments = seg_q[i];
    end
  end

endmodule

//--- src/digit_scanner.sv
/*
  steps a one-hot digit enable from ones to ten-thousands, scan_div + 1 cycles per digit
  a new scan_div is picked up at the next slot boundary
*/
`timescale 1ns/1ps

module digit_scanner (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        enable,
  input  logic [7:0]                  scan_div,
  output bcd_display_pkg::digit_sel_t digit_sel,
  output logic                        frame_done
);

  bcd_display_pkg::scan_state_t state;
  bcd_display_pkg::digit_sel_t  sel_q;
  logic [7:0]                   slot_cnt;
  logic [7:0]                   slot_div;
  logic                         slot_end;

  assign slot_end = (slot_cnt == slot_div);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= bcd_display_pkg::SCAN_IDLE;
      sel_q    <= '0;
      slot_cnt <= '0;
      slot_div <= '0;
    end else begin
      case (state)
        bcd_display_pkg::SCAN_IDLE: begin
          if (enable) begin
            state    <= bcd_display_pkg::SCAN_RUN;
            sel_q    <= bcd_display_pkg::digit_sel_t'(1);
            slot_cnt <= '0;
            slot_div <= scan_div;
          end
        end
        default: begin
          if (!enable) begin
            state <= bcd_display_pkg::SCAN_IDLE;
            sel_q <= '0;
          end else if (slot_end) begin
            // rotate up, wrapping from ten-thousands back to ones
            sel_q    <= {sel_q[bcd_display_pkg::NUM_DIGITS-2:0],
                         sel_q[bcd_display_pkg::NUM_DIGITS-1]};
            slot_cnt <= '0;
            slot_div <= scan_div;
          end else begin
            slot_cnt <= slot_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  assign digit_sel  = sel_q;
  assign frame_done = (state == bcd_display_pkg::SCAN_RUN) && enable && slot_end &&
                      sel_q[bcd_display_pkg::NUM_DIGITS-1];

endmodule

//--- src/display_config.sv
/*
  write-only configuration registers, no readback
  address 0 holds enable in bit 0 and blank_lz in bit 1, address 1 holds scan_div
*/
`timescale 1ns/1ps

module display_config (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          cfg_we,
  input  logic                          cfg_addr,
  input  logic [7:0]                    cfg_wdata,
  output bcd_display_pkg::display_cfg_t cfg
);

  bcd_display_pkg::display_cfg_t cfg_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg_q <= '0;
    end else if (cfg_we) begin
      if (cfg_addr == bcd_display_pkg::CFG_ADDR_CTRL) begin
        cfg_q.enable   <= cfg_wdata[0];
        cfg_q.blank_lz <= cfg_wdata[1];
      end else begin
        // only the scan register remains at address 1
        cfg_q.scan_div <= cfg_wdata;
      end
    end
  end

  assign cfg = cfg_q;

endmodule

//--- src/sample_queue.sv
/*
  credit-based receive queue, never refuses a valid sample
  the sender must not hold more than QUEUE_DEPTH samples outstanding
*/
`timescale 1ns/1ps

module sample_queue (
  input  logic                     clk,
  input  logic                     rst_n,
  input  bcd_display_pkg::sample_t sample,
  input  logic                     pop_req,
  output bcd_display_pkg::sample_t pop_sample,
  output logic                     credit_return
);

  typedef logic [$clog2(bcd_display_pkg::QUEUE_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(bcd_display_pkg::QUEUE_DEPTH+1)-1:0] cnt_t;

  bcd_display_pkg::bin16_t mem [bcd_display_pkg::QUEUE_DEPTH];
  ptr_t wr_ptr;
  ptr_t rd_ptr;
  cnt_t count;
  logic push;
  logic pop;

  assign push = sample.valid;
  // a pop request against an empty queue is dropped
  assign pop  = pop_req && (count != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_t'(bcd_display_pkg::QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_t'(bcd_display_pkg::QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
      credit_return <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= sample.value;
    end
  end

  assign pop_sample.valid = pop;
  assign pop_sample.value = mem[rd_ptr];

endmodule
